/* source/ps2_defines.svh */
/* PS/2 mouse host sizes
   inhibit and watchdog timer widths, position counter widths */

`ifndef PS2_DEFINES_SVH
`define PS2_DEFINES_SVH

// ----------------------------------------
// init timing, in clk cycles as log2
// ----------------------------------------
`define PS2_INHIBIT_BITS 12	// clock held low for 2^12 cycles
`define PS2_TIMEOUT_BITS 16	// watchdog, must be >= inhibit bits

// ----------------------------------------
// position counters
// ----------------------------------------
`define MOUSE_X_BITS 8	// x counter width, wraps
`define MOUSE_Y_BITS 8	// y counter width, wraps

`endif

/* source/ps2_link_pkg.sv */
/* PS/2 link protocol constants
   command and reply codes, device frame length */

`default_nettype none

package ps2_link_pkg;

	// ----------------------------------------
	// host to device commands
	// ----------------------------------------
	localparam logic [7:0] PS2_CMD_ENABLE = 8'hF4;	// enable data reporting

	// ----------------------------------------
	// device to host replies
	// ----------------------------------------
	localparam logic [7:0] PS2_REPLY_ACK = 8'hFA;	// command acknowledge

	// start + 8 data + parity + stop
	localparam int PS2_FRAME_BITS = 11;

endpackage

`default_nettype wire

/* source/mouse_pkg.sv */
/* mouse packet types
   first packet byte seen either raw or as the status/button view */

`default_nettype none

package mouse_pkg;

	// one packet byte, status view used for byte 0 only
	typedef union packed
	{
		logic [7:0] raw;	// delta bytes
		struct packed
		{
			logic y_ovf;	// y overflow
			logic x_ovf;	// x overflow
			logic y_sign;	// y delta bit 8
			logic x_sign;	// x delta bit 8
			logic sync_one;	// always 1 in a status byte
			logic middle;	// middle button
			logic right;	// right button
			logic left;	// left button
		} status;
	} mouse_byte_u;

	// standard packet, no wheel byte
	localparam int MOUSE_PACKET_BYTES = 3;

endpackage

`default_nettype wire

/* source/ps2_line_sync.sv */
/* PS/2 line synchronizer
   two-flop sync of mouse clock and data, registered falling-edge strobe */

`timescale 1ns/1ps
`default_nettype none

module ps2_line_sync
(
	input wire clk,
	input wire mrreset,
	input wire ps2_clk_in,	// mouse clock line
	input wire ps2_dat_in,	// mouse data line
	output logic bit_fall,	// one cycle per falling clock edge
	output logic bit_data	// data level at that edge
);

	logic clk_s1, clk_s2, clk_d;	// clock sync chain + last sample
	logic dat_s1, dat_s2;	// data sync chain

	always_ff @(posedge clk)
	begin
		if (mrreset)
		begin
			clk_s1 <= 1'b1;	// idle lines are high
			clk_s2 <= 1'b1;
			clk_d <= 1'b1;
			dat_s1 <= 1'b1;
			dat_s2 <= 1'b1;
			bit_fall <= 1'b0;
			bit_data <= 1'b1;
		end
		else
		begin
			clk_s1 <= ps2_clk_in;
			clk_s2 <= clk_s1;
			clk_d <= clk_s2;
			dat_s1 <= ps2_dat_in;
			dat_s2 <= dat_s1;
			bit_fall <= clk_d & ~clk_s2;	// high then low
			bit_data <= dat_s2;	// aligned with the edge compare
		end
	end

endmodule

`default_nettype wire

/* source/ps2_frame_rx.sv */
/* PS/2 device-to-host frame receiver
   11-bit shifter, byte strobe when start bit reaches bit 0, start/stop/parity check */

`timescale 1ns/1ps
`default_nettype none

module ps2_frame_rx
(
	input wire clk,
	input wire mrreset,
	input wire flush,	// hold shifter empty
	input wire bit_fall,	// bit strobe from line sync
	input wire bit_data,	// sampled data bit
	output logic byte_valid,	// one cycle, frame complete
	output logic [7:0] byte_data,	// received data byte
	output logic parity_err	// bad odd parity or stop bit
);

	import ps2_link_pkg::*;

	localparam logic [PS2_FRAME_BITS-1:0] RX_EMPTY = '1;

	logic [PS2_FRAME_BITS-1:0] shreg;	// {stop, parity, d7..d0, start}
	logic frame_done;

	// ----------------------------------------
	// shifter
	// ----------------------------------------
	// ones shift out ahead of the start zero, so bit 0 going low
	// means all 11 bits are in
	assign frame_done = ~shreg[0];

	always_ff @(posedge clk)
	begin
		if (mrreset || flush || frame_done)
		begin
			shreg <= RX_EMPTY;	// reload, same cycle as byte_valid
		end
		else if (bit_fall)
		begin
			shreg <= {bit_data, shreg[PS2_FRAME_BITS-1:1]};	// lsb first
		end
	end

	// ----------------------------------------
	// frame outputs
	// ----------------------------------------
	assign byte_valid = frame_done;
	assign byte_data = shreg[8:1];	// data bits, lsb at bit 1

	// data + parity must hold an odd count of ones, stop must be 1
	assign parity_err = ~(^shreg[9:1]) | ~shreg[PS2_FRAME_BITS-1];

endmodule

`default_nettype wire

/* source/ps2_frame_tx.sv */
/* PS/2 host-to-device command sender
   shifts out the enable command with odd parity on device clock edges, then waits for ack */

`timescale 1ns/1ps
`default_nettype none

module ps2_frame_tx
(
	input wire clk,
	input wire mrreset,
	input wire tx_start,	// load and start a command frame
	input wire bit_fall,	// device clock falling edge
	output logic tx_done,	// one cycle, ack clock seen
	output logic ps2_dat_out	// 0 pulls data low
);

	import ps2_link_pkg::*;

	localparam int TX_BITS = PS2_FRAME_BITS + 1;	// frame plus guard
	localparam logic [TX_BITS-1:0] TX_IDLE = TX_BITS'(1);	// only guard left
	localparam logic [TX_BITS-1:0] TX_FRAME =
		{1'b1, 1'b1, ~(^PS2_CMD_ENABLE), PS2_CMD_ENABLE, 1'b0};	// guard, stop, par, data, start

	logic [TX_BITS-1:0] shreg;	// bit 0 drives the data line
	logic busy;
	logic last_shift;	// this edge is the ack clock

	assign busy = (shreg != TX_IDLE);

	// only stop and guard remain, so the next edge is the device ack
	assign last_shift = (shreg[TX_BITS-1:1] == (TX_BITS-1)'(1));

	// ----------------------------------------
	// shifter
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (mrreset)
		begin
			shreg <= TX_IDLE;	// data released
			tx_done <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			if (tx_start)
			begin
				shreg <= TX_FRAME;	// start bit low = request to send
			end
			else if (busy && bit_fall)
			begin
				shreg <= {1'b0, shreg[TX_BITS-1:1]};	// next bit on falling edge
				tx_done <= last_shift;	// guard reached, line released
			end
		end
	end

	assign ps2_dat_out = shreg[0];

endmodule

`default_nettype wire

/* source/ps2_init_ctrl.sv */
/* PS/2 mouse init controller
   inhibit, send enable command, wait for ack, then stream; restart on timeout or bad reply */

`timescale 1ns/1ps
`default_nettype none

`include "ps2_defines.svh"

module ps2_init_ctrl
(
	input wire clk,
	input wire mrreset,
	input wire tx_done,	// command frame finished
	input wire byte_valid,	// received byte strobe
	input wire [7:0] byte_data,
	input wire parity_err,
	output logic tx_start,	// one cycle, start command
	output logic flush,	// keep receiver empty
	output logic ps2_clk_out,	// 0 pulls clock low
	output logic link_up	// mouse streaming
);

	import ps2_link_pkg::*;

	localparam logic [1:0] ST_INHIBIT = 2'd0;	// clock held low
	localparam logic [1:0] ST_SEND = 2'd1;	// command going out
	localparam logic [1:0] ST_WAIT_ACK = 2'd2;	// expecting FA
	localparam logic [1:0] ST_STREAM = 2'd3;	// packets flowing

	logic [1:0] state;
	logic [`PS2_TIMEOUT_BITS-1:0] timer;	// shared inhibit and watchdog count
	logic inhibit_done, wd_expired, ack_ok;

	// timer restarts from 0 on every state change, low bits give the inhibit
	assign inhibit_done = &timer[`PS2_INHIBIT_BITS-1:0];
	assign wd_expired = &timer;
	assign ack_ok = byte_valid & ~parity_err & (byte_data == PS2_REPLY_ACK);

	// ----------------------------------------
	// state machine
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (mrreset)
		begin
			state <= ST_INHIBIT;
			timer <= '0;
		end
		else
		begin
			timer <= timer + 1'b1;
			case (state)
				ST_INHIBIT:
					if (inhibit_done)
					begin
						state <= ST_SEND;	// release clock, tx_start now
						timer <= '0;
					end
				ST_SEND:
					if (tx_done)
					begin
						state <= ST_WAIT_ACK;
						timer <= '0;
					end
					else if (wd_expired)
					begin
						state <= ST_INHIBIT;	// device never clocked
						timer <= '0;
					end
				ST_WAIT_ACK:
					if (ack_ok)
					begin
						state <= ST_STREAM;
					end
					else if (byte_valid || wd_expired)
					begin
						state <= ST_INHIBIT;	// wrong reply, parity or timeout
						timer <= '0;
					end
				default:
					timer <= timer;	// stream, watchdog idle
			endcase
		end
	end

	assign tx_start = (state == ST_INHIBIT) & inhibit_done;
	assign flush = (state == ST_INHIBIT) | (state == ST_SEND);	// no readback of own bits
	assign ps2_clk_out = (state != ST_INHIBIT);
	assign link_up = (state == ST_STREAM);

endmodule

`default_nettype wire

/* source/mouse_packet_decode.sv */
/* mouse packet decoder
   collects status, dx and dy bytes, resyncs on the status sync bit, builds 9-bit deltas */

`timescale 1ns/1ps
`default_nettype none

module mouse_packet_decode
(
	input wire clk,
	input wire mrreset,
	input wire link_up,	// only decode while streaming
	input wire byte_valid,
	input wire [7:0] byte_data,
	input wire parity_err,
	output logic pkt_valid,	// one cycle, packet ready
	output mouse_pkg::mouse_byte_u pkt_status,	// status byte of the packet
	output logic signed [8:0] pkt_dx,
	output logic signed [8:0] pkt_dy
);

	import mouse_pkg::*;

	localparam int IDX_BITS = $clog2(MOUSE_PACKET_BYTES);
	localparam logic [IDX_BITS-1:0] IDX_LAST = IDX_BITS'(MOUSE_PACKET_BYTES - 1);

	mouse_byte_u in_byte;	// incoming byte, both views
	mouse_byte_u status_q;	// held status byte
	logic [7:0] dx_q;	// held x delta
	logic [IDX_BITS-1:0] idx;	// byte position in packet

	assign in_byte.raw = byte_data;

	always_ff @(posedge clk)
	begin
		pkt_valid <= 1'b0;
		if (mrreset || !link_up)
		begin
			pkt_valid <= 1'b0;
			idx <= '0;
		end
		else if (byte_valid)
		begin
			if (parity_err)
			begin
				idx <= '0;	// drop byte, restart packet
			end
			else if (idx == '0)
			begin
				status_q <= in_byte;
				if (in_byte.status.sync_one)
				begin
					idx <= idx + 1'b1;	// else stay, resync
				end
			end
			else if (idx == IDX_LAST)
			begin
				pkt_status <= status_q;
				pkt_dx <= {status_q.status.x_sign, dx_q};
				pkt_dy <= {status_q.status.y_sign, in_byte.raw};
				pkt_valid <= 1'b1;
				idx <= '0;
			end
			else
			begin
				dx_q <= in_byte.raw;
				idx <= idx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* source/mouse_position.sv */
/* mouse position and buttons
   x adds dx, y subtracts dy, both wrap at counter width; buttons from the status byte */

`timescale 1ns/1ps
`default_nettype none

`include "ps2_defines.svh"

module mouse_position
(
	input wire clk,
	input wire mrreset,
	input wire pkt_valid,
	input wire mouse_pkg::mouse_byte_u pkt_status,
	input wire signed [8:0] pkt_dx,
	input wire signed [8:0] pkt_dy,
	output logic [`MOUSE_X_BITS-1:0] x_count,
	output logic [`MOUSE_Y_BITS-1:0] y_count,
	output logic [2:0] buttons	// {middle, right, left}
);

	localparam int XW = `MOUSE_X_BITS;
	localparam int YW = `MOUSE_Y_BITS;

	always_ff @(posedge clk)
	begin
		if (mrreset)
		begin
			x_count <= '0;
			y_count <= '0;
			buttons <= 3'b000;
		end
		else if (pkt_valid)
		begin
			x_count <= x_count + XW'(pkt_dx);	// sign-extend or truncate
			y_count <= y_count - YW'(pkt_dy);	// y counts downward
			buttons <= {pkt_status.status.middle, pkt_status.status.right,
				pkt_status.status.left};
		end
	end

endmodule

`default_nettype wire

/* source/ps2_mouse_top.sv */
/* PS/2 mouse host top
   line sync, frame rx/tx, init control, packet decode and position counters */

`timescale 1ns/1ps
`default_nettype none

`include "ps2_defines.svh"

module ps2_mouse_top
(
	input wire clk,
	input wire mrreset,
	input wire ps2_clk_in,	// mouse clock line
	input wire ps2_dat_in,	// mouse data line
	output logic ps2_clk_out,	// 0 pulls clock low
	output logic ps2_dat_out,	// 0 pulls data low
	output logic link_up,	// init done, streaming
	output logic [`MOUSE_X_BITS-1:0] x_count,
	output logic [`MOUSE_Y_BITS-1:0] y_count,
	output logic [2:0] buttons	// {middle, right, left}
);

	import mouse_pkg::*;

	logic bit_fall, bit_data;	// line sync strobes
	logic byte_valid, parity_err;	// receiver strobes
	logic [7:0] byte_data;
	logic tx_start, tx_done, flush;	// init control handshake
	logic pkt_valid;	// packet strobe
	mouse_byte_u pkt_status;
	logic signed [8:0] pkt_dx, pkt_dy;

	// ----------------------------------------
	// PS/2 link
	// ----------------------------------------
	ps2_line_sync u_line_sync (.clk(clk), .mrreset(mrreset), .ps2_clk_in(ps2_clk_in),
		.ps2_dat_in(ps2_dat_in), .bit_fall(bit_fall), .bit_data(bit_data));

	ps2_frame_rx u_frame_rx (.clk(clk), .mrreset(mrreset), .flush(flush),
		.bit_fall(bit_fall), .bit_data(bit_data), .byte_valid(byte_valid),
		.byte_data(byte_data), .parity_err(parity_err));

	ps2_frame_tx u_frame_tx (.clk(clk), .mrreset(mrreset), .tx_start(tx_start),
		.bit_fall(bit_fall), .tx_done(tx_done), .ps2_dat_out(ps2_dat_out));

	ps2_init_ctrl u_init_ctrl (.clk(clk), .mrreset(mrreset), .tx_done(tx_done),
		.byte_valid(byte_valid), .byte_data(byte_data), .parity_err(parity_err),
		.tx_start(tx_start), .flush(flush), .ps2_clk_out(ps2_clk_out),
		.link_up(link_up));

	// ----------------------------------------
	// mouse packets
	// ----------------------------------------
	mouse_packet_decode u_packet_decode (.clk(clk), .mrreset(mrreset), .link_up(link_up),
		.byte_valid(byte_valid), .byte_data(byte_data), .parity_err(parity_err),
		.pkt_valid(pkt_valid), .pkt_status(pkt_status), .pkt_dx(pkt_dx),
		.pkt_dy(pkt_dy));

	mouse_position u_position (.clk(clk), .mrreset(mrreset), .pkt_valid(pkt_valid),
		.pkt_status(pkt_status), .pkt_dx(pkt_dx), .pkt_dy(pkt_dy),
		.x_count(x_count), .y_count(y_count), .buttons(buttons));

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
/* testbench clock and reset
   free-running clk, mrreset held for a few cycles and released on a falling edge */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
#(
	parameter int PERIOD_NS = 20,
	parameter int RESET_CYCLES = 2
)
(
	output logic clk,
	output logic mrreset
);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

	initial
	begin
		mrreset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		mrreset = 1'b0;	// released between edges
	end

endmodule

`default_nettype wire

/* verif/tb_ps2_mouse.sv */
/* PS/2 mouse host testbench
   mouse device model, reference position model, init, movement and recovery checks */

`timescale 1ns/1ps
`default_nettype none

`include "ps2_defines.svh"

module tb_ps2_mouse;

	import ps2_link_pkg::*;
	import mouse_pkg::*;

	localparam int XW = `MOUSE_X_BITS;
	localparam int YW = `MOUSE_Y_BITS;
	localparam int RW = XW + YW + 3;	// {x, y, buttons}
	localparam int HALF_CYCLES = 10;	// device clock half period
	localparam int FRAME_CYCLES = PS2_FRAME_BITS * 2 * HALF_CYCLES;
	localparam int RANDOM_PACKETS = 40;
	localparam int TOTAL_PACKETS = RANDOM_PACKETS + 2;	// one more after each recovery case
	localparam int SETTLE_CYCLES = 20;
	localparam int INHIBIT_CYCLES = 1 << `PS2_INHIBIT_BITS;
	localparam int WATCHDOG_CYCLES = 2 * (INHIBIT_CYCLES + (1 << `PS2_TIMEOUT_BITS))
		+ 40 * FRAME_CYCLES * TOTAL_PACKETS;

	logic clk, mrreset;
	logic dev_clk, dev_dat;	// 0 pulls the line low from the device
	wire ps2_clk_line, ps2_dat_line;	// wired-AND of both sides
	wire ps2_clk_out, ps2_dat_out, link_up;
	wire [XW-1:0] x_count;
	wire [YW-1:0] y_count;
	wire [2:0] buttons;	// {middle, right, left}

	int error_count = 0;
	int check_count = 0;
	int checks_requested = 0;
	int checks_done = 0;
	logic [RW-1:0] exp_state;	// reference {x, y, buttons}
	logic [31:0] rng_state;
	event check_req;

	// pull-up unless a side drives 0
	assign ps2_clk_line = dev_clk & (ps2_clk_out !== 1'b0);
	assign ps2_dat_line = dev_dat & (ps2_dat_out !== 1'b0);

	tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) u_clock_gen (.clk(clk),
		.mrreset(mrreset));

	ps2_mouse_top u_dut (.clk(clk), .mrreset(mrreset), .ps2_clk_in(ps2_clk_line),
		.ps2_dat_in(ps2_dat_line), .ps2_clk_out(ps2_clk_out), .ps2_dat_out(ps2_dat_out),
		.link_up(link_up), .x_count(x_count), .y_count(y_count), .buttons(buttons));

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// 9-bit two's complement deltas with sign bits from the status byte
	function automatic logic [RW-1:0] reference_step(input logic [RW-1:0] cur,
		input mouse_byte_u st, input logic [7:0] dx, input logic [7:0] dy);
		int x_move, y_move, x_sum, y_sum;
		x_move = st.status.x_sign ? int'(dx) - 256 : int'(dx);
		y_move = st.status.y_sign ? int'(dy) - 256 : int'(dy);
		x_sum = int'(cur[RW-1 -: XW]) + x_move;	// x moves right
		y_sum = int'(cur[YW+2 -: YW]) - y_move;	// y counts downward
		return {x_sum[XW-1:0], y_sum[YW-1:0], st.status.middle, st.status.right,
			st.status.left};
	endfunction

	// ----------------------------------------
	// reporting and checks
	// ----------------------------------------
	task automatic finish_run();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
		begin
			$display("Simulation passed");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	task automatic report_failure(input string reason);
		$display("ERROR: %s", reason);
		error_count++;
	endtask

	task automatic expect_bit(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected)
		begin
			$display("FAIL %s: expected 0x%h, got 0x%h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic expect_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			$display("FAIL %s: expected 0x%h, got 0x%h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic compare_counts(input logic [XW-1:0] exp_x, input logic [YW-1:0] exp_y);
		check_count += 2;
		if (x_count !== exp_x)
		begin
			$display("FAIL x_count: expected 0x%h, got 0x%h", exp_x, x_count);
			error_count++;
		end
		if (y_count !== exp_y)
		begin
			$display("FAIL y_count: expected 0x%h, got 0x%h", exp_y, y_count);
			error_count++;
		end
	endtask

	task automatic compare_buttons(input mouse_byte_u expected);
		logic [2:0] exp_bits;
		exp_bits = {expected.status.middle, expected.status.right, expected.status.left};
		check_count++;
		if (buttons !== exp_bits)
		begin
			$display("FAIL buttons: expected 0x%h, got 0x%h", exp_bits, buttons);
			error_count++;
		end
	endtask

	task automatic request_check();
		checks_requested++;
		-> check_req;	// compare process picks it up after settling
	endtask

	// ----------------------------------------
	// device model
	// ----------------------------------------
	task automatic half_period();
		repeat (HALF_CYCLES) @(negedge clk);
	endtask

	task automatic wait_clk_out(input logic level, input int limit, output bit seen);
		int n;
		seen = 1'b0;
		for (n = 0; n < limit && !seen; n++)
		begin
			@(negedge clk);
			seen = (ps2_clk_out === level);
		end
	endtask

	task automatic wait_link_up(input int limit, output bit seen);
		int n;
		seen = 1'b0;
		for (n = 0; n < limit && !seen; n++)
		begin
			@(negedge clk);
			seen = (link_up === 1'b1);
		end
	endtask

	// device-to-host frame sent lsb first with optional bad parity
	task automatic send_frame(input logic [7:0] data, input logic bad_parity);
		logic [PS2_FRAME_BITS-1:0] bits;
		int i;
		bits = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};	// stop, parity, data, start
		for (i = 0; i < PS2_FRAME_BITS; i++)
		begin
			dev_dat = bits[i];	// set while clock high
			half_period();
			dev_clk = 1'b0;	// host samples here
			half_period();
			dev_clk = 1'b1;
		end
		dev_dat = 1'b1;
		half_period();	// idle gap between frames
		half_period();
	endtask

	// clocks in a host-to-device frame and answers with the ack clock
	task automatic receive_command(output logic [7:0] data, output logic parity,
		output logic stop);
		logic [9:0] bits;
		int i;
		bit seen;
		wait_clk_out(1'b1, 2 * INHIBIT_CYCLES, seen);
		if (!seen)
		begin
			report_failure("host never released the clock after the inhibit");
		end
		else if (ps2_dat_line !== 1'b0)
		begin
			report_failure("host released the clock without a request to send");
		end
		half_period();
		for (i = 0; i < 10; i++)
		begin
			dev_clk = 1'b0;	// host moves on to next bit
			half_period();
			bits[i] = ps2_dat_line;	// sample before rising edge
			dev_clk = 1'b1;
			half_period();
		end
		dev_dat = 1'b0;	// ack
		dev_clk = 1'b0;
		half_period();
		dev_clk = 1'b1;
		half_period();
		dev_dat = 1'b1;
		{stop, parity, data} = bits;
	endtask

	task automatic check_command(input logic [7:0] cmd, input logic par, input logic stop);
		expect_byte("command", PS2_CMD_ENABLE, cmd);
		expect_bit("command parity", 1'b1, ^{cmd, par});	// odd over data and parity
		expect_bit("command stop", 1'b1, stop);
	endtask

	task automatic send_packet(input mouse_byte_u st, input logic [7:0] dx,
		input logic [7:0] dy);
		send_frame(st.raw, 1'b0);
		send_frame(dx, 1'b0);
		send_frame(dy, 1'b0);
		exp_state = reference_step(exp_state, st, dx, dy);
		request_check();
	endtask

	task automatic send_random_packet();
		mouse_byte_u st;
		rng_state = xorshift32(rng_state);
		st.raw = rng_state[7:0];	// random buttons, signs, overflows
		st.status.sync_one = 1'b1;
		send_packet(st, rng_state[15:8], rng_state[23:16]);
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial
	begin : stimulus
		logic [7:0] cmd;
		logic par, stop;
		mouse_byte_u st;
		bit seen;
		int n;
		dev_clk = 1'b1;	// lines released
		dev_dat = 1'b1;
		rng_state = 32'hce01_0d87;
		exp_state = '0;
		@(posedge clk);
		while (mrreset)
		begin
			@(posedge clk);
		end
		@(negedge clk);
		expect_bit("link_up", 1'b0, link_up);
		expect_bit("ps2_dat_out", 1'b1, ps2_dat_out);
		expect_bit("ps2_clk_out", 1'b0, ps2_clk_out);	// starts in inhibit
		request_check();

		// a resend reply to the first command forces a new inhibit
		receive_command(cmd, par, stop);
		check_command(cmd, par, stop);
		half_period();
		send_frame(8'hFE, 1'b0);
		wait_clk_out(1'b0, 8 * HALF_CYCLES, seen);
		if (!seen)
		begin
			report_failure("wrong reply did not bring back the clock inhibit");
		end
		expect_bit("link_up", 1'b0, link_up);

		receive_command(cmd, par, stop);	// second try
		check_command(cmd, par, stop);
		half_period();
		send_frame(PS2_REPLY_ACK, 1'b0);
		wait_link_up(8 * HALF_CYCLES, seen);
		if (!seen)
		begin
			report_failure("link_up did not rise after the acknowledge");
		end

		for (n = 0; n < RANDOM_PACKETS; n++)
		begin
			send_random_packet();
		end

		// bad parity on the dx byte drops the packet
		rng_state = xorshift32(rng_state);
		st.raw = rng_state[7:0];
		st.status.sync_one = 1'b1;
		send_frame(st.raw, 1'b0);
		send_frame(rng_state[15:8], 1'b1);
		request_check();	// outputs unchanged
		send_random_packet();

		// leading byte without the sync bit is skipped
		rng_state = xorshift32(rng_state);
		st.raw = rng_state[7:0];
		st.status.sync_one = 1'b0;
		send_frame(st.raw, 1'b0);
		request_check();
		send_random_packet();

		wait (checks_done == checks_requested);
		finish_run();
	end

	// compares against the reference once the last frame has settled
	initial
	begin : compare_proc
		mouse_byte_u exp_btn;
		forever
		begin
			@(check_req);
			repeat (SETTLE_CYCLES) @(negedge clk);
			exp_btn.raw = '0;
			exp_btn.status.middle = exp_state[2];
			exp_btn.status.right = exp_state[1];
			exp_btn.status.left = exp_state[0];
			compare_counts(exp_state[RW-1 -: XW], exp_state[YW+2 -: YW]);
			compare_buttons(exp_btn);
			checks_done++;
		end
	end

	initial
	begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		report_failure("watchdog expired, the run hung waiting on the DUT or the device model");
		finish_run();
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+source
source/ps2_link_pkg.sv
source/mouse_pkg.sv
source/ps2_line_sync.sv
source/ps2_frame_rx.sv
source/ps2_frame_tx.sv
source/ps2_init_ctrl.sv
source/mouse_packet_decode.sv
source/mouse_position.sv
source/ps2_mouse_top.sv
verif/tb_clock_gen.sv
verif/tb_ps2_mouse.sv

/* Bender.yml */
package:
  name: ps2_mouse_host

sources:
  - include_dirs:
      - source
    files:
      - source/ps2_link_pkg.sv
      - source/mouse_pkg.sv
      - source/ps2_line_sync.sv
      - source/ps2_frame_rx.sv
      - source/ps2_frame_tx.sv
      - source/ps2_init_ctrl.sv
      - source/mouse_packet_decode.sv
      - source/mouse_position.sv
      - source/ps2_mouse_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_ps2_mouse.sv
